//--- rtl/core_pkg.sv
package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] instr_t;
  typedef logic [6:0]  opcode_t;

  // RV32I major opcodes of the supported subset
  localparam opcode_t op_reg    = 7'b0110011;
  localparam opcode_t op_imm    = 7'b0010011;
  localparam opcode_t op_load   = 7'b0000011;
  localparam opcode_t op_store  = 7'b0100011;
  localparam opcode_t op_branch = 7'b1100011;
  localparam opcode_t op_jal    = 7'b1101111;

  typedef enum logic [2:0] {st_fetch, st_decode, st_exec, st_mem, st_wb} ctrl_state_e;

  typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_xor} alu_op_e;

  // AXI-lite channel payloads
  typedef struct packed {
    word_t addr;
  } rd_req_t;

  typedef struct packed {
    word_t      data;
    logic [1:0] resp;
  } rd_rsp_t;

  // Shared by AW and W
  typedef struct packed {
    word_t      addr;
    word_t      data;
    logic [3:0] strb;
  } wr_req_t;

  typedef struct packed {
    logic [1:0] resp;
  } wr_rsp_t;

endpackage

//--- rtl/core_registers.sv
`timescale 1ns/1ps

module core_registers import core_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t raddr1,
  input  reg_addr_t raddr2,
  output word_t     rdata1,
  output word_t     rdata2,
  input  logic      we,
  input  reg_addr_t waddr,
  input  word_t     wdata
);

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 always reads as zero
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- rtl/core_ifetch.sv
`timescale 1ns/1ps

module core_ifetch import core_pkg::*; #(
  parameter word_t reset_pc = 32'h0000_0000
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    fetch_start,
  output logic    fetch_done,
  output instr_t  instr,
  output word_t   pc,
  input  logic    pc_write,
  input  word_t   pc_next,
  output rd_req_t req,
  output logic    req_valid,
  input  logic    req_ready,
  input  rd_rsp_t rsp,
  input  logic    rsp_valid,
  output logic    rsp_ready
);

  assign req = '{addr: pc};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc         <= reset_pc;
      req_valid  <= 1'b0;
      rsp_ready  <= 1'b0;
      fetch_done <= 1'b0;
    end else begin
      fetch_done <= 1'b0;
      if (pc_write) begin
        pc <= pc_next;
      end
      // AR transfer followed by the matching R beat
      if (fetch_start) begin
        req_valid <= 1'b1;
      end else if (req_valid && req_ready) begin
        req_valid <= 1'b0;
        rsp_ready <= 1'b1;
      end
      if (rsp_ready && rsp_valid) begin
        rsp_ready  <= 1'b0;
        fetch_done <= 1'b1;
      end
    end
  end

  // Latched instruction word
  always_ff @(posedge clk) begin
    if (rsp_ready && rsp_valid) begin
      instr <= rsp.data;
    end
  end

  // PC must not move while the fetch address waits on the bus
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid && !req_ready |=> req_valid && $stable(req.addr));

endmodule

//--- rtl/core_lsu.sv
`timescale 1ns/1ps

module core_lsu import core_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    mem_start,
  input  logic    mem_write,
  input  word_t   addr,
  input  word_t   wdata,
  output logic    mem_done,
  output word_t   rdata,
  output rd_req_t req,
  output logic    req_valid,
  input  logic    req_ready,
  input  rd_rsp_t rsp,
  input  logic    rsp_valid,
  output logic    rsp_ready,
  output wr_req_t aw,
  output logic    awvalid,
  input  logic    awready,
  output wr_req_t w,
  output logic    wvalid,
  input  logic    wready,
  input  wr_rsp_t b,
  input  logic    bvalid,
  output logic    bready
);

  word_t addr_q;
  word_t wdata_q;

  // Word accesses only, so all byte lanes enabled
  assign req = '{addr: addr_q};
  assign aw  = '{addr: addr_q, data: wdata_q, strb: 4'hF};
  assign w   = aw;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_valid <= 1'b0;
      rsp_ready <= 1'b0;
      awvalid   <= 1'b0;
      wvalid    <= 1'b0;
      bready    <= 1'b0;
      mem_done  <= 1'b0;
    end else begin
      mem_done <= 1'b0;
      if (mem_start) begin
        req_valid <= !mem_write;
        awvalid   <= mem_write;
        wvalid    <= mem_write;
        bready    <= mem_write;
      end
      // Load path
      if (req_valid && req_ready) begin
        req_valid <= 1'b0;
        rsp_ready <= 1'b1;
      end
      if (rsp_ready && rsp_valid) begin
        rsp_ready <= 1'b0;
        mem_done  <= 1'b1;
      end
      // AW and W retire on their own handshakes
      if (awvalid && awready) begin
        awvalid <= 1'b0;
      end
      if (wvalid && wready) begin
        wvalid <= 1'b0;
      end
      // B follows both transfers and its resp is not used
      if (bready && bvalid) begin
        bready   <= 1'b0;
        mem_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_start) begin
      addr_q  <= addr;
      wdata_q <= wdata;
    end
    if (rsp_ready && rsp_valid) begin
      rdata <= rsp.data;
    end
  end

  a_no_write_in_read: assert property (@(posedge clk) disable iff (!rst_n)
    (req_valid || rsp_ready) |-> !(awvalid || wvalid));

endmodule

//--- rtl/core_rd_arbiter.sv
`timescale 1ns/1ps

module core_rd_arbiter import core_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  rd_req_t f_req,
  input  rd_req_t l_req,
  input  logic    f_valid,
  input  logic    l_valid,
  output logic    f_ready,
  output logic    l_ready,
  output logic    f_rvalid,
  output logic    l_rvalid,
  input  logic    f_rready,
  input  logic    l_rready,
  output rd_req_t ar,
  output logic    arvalid,
  input  logic    arready,
  input  logic    rvalid,
  output logic    rready
);

  logic f_gnt;
  logic l_gnt;
  logic busy;
  logic pend;
  logic pend_l;
  logic sel_l;

  assign busy = f_gnt || l_gnt;

  // Keep the choice fixed while an AR is stalled so its payload stays put
  assign sel_l = pend ? pend_l : l_valid;

  assign arvalid = !busy && (sel_l ? l_valid : f_valid);
  assign ar      = sel_l ? l_req : f_req;
  assign l_ready = !busy && sel_l && arready;
  assign f_ready = !busy && !sel_l && arready;

  // R routed by the locked grant
  assign f_rvalid = f_gnt && rvalid;
  assign l_rvalid = l_gnt && rvalid;
  assign rready   = (f_gnt && f_rready) || (l_gnt && l_rready);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      f_gnt  <= 1'b0;
      l_gnt  <= 1'b0;
      pend   <= 1'b0;
      pend_l <= 1'b0;
    end else begin
      pend   <= arvalid && !arready;
      pend_l <= sel_l;
      if (arvalid && arready) begin
        l_gnt <= sel_l;
        f_gnt <= !sel_l;
      end else if (rvalid && rready) begin
        l_gnt <= 1'b0;
        f_gnt <= 1'b0;
      end
    end
  end

  // One grant at a time and held only by a master waiting for its R beat
  a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({f_gnt, l_gnt}) && (!f_gnt || f_rready) && (!l_gnt || l_rready));

endmodule

//--- rtl/core_control.sv
`timescale 1ns/1ps

module core_control import core_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  output logic      fetch_start,
  input  logic      fetch_done,
  input  instr_t    instr,
  input  word_t     pc,
  output logic      pc_write,
  output word_t     pc_next,
  output reg_addr_t raddr1,
  output reg_addr_t raddr2,
  input  word_t     rdata1,
  input  word_t     rdata2,
  output logic      we,
  output reg_addr_t waddr,
  output word_t     wdata,
  output logic      mem_start,
  output logic      mem_write,
  output word_t     mem_addr,
  output word_t     mem_wdata,
  input  logic      mem_done,
  input  word_t     mem_rdata
);

  ctrl_state_e state;
  logic        boot;
  opcode_t     op;
  alu_op_e     alu_op;
  word_t       imm;
  opcode_t     op_q;
  reg_addr_t   rd_q;
  logic [2:0]  f3_q;
  alu_op_e     alu_op_q;
  word_t       a_q;
  word_t       b_q;
  word_t       imm_q;
  word_t       alu_b;
  word_t       alu_y;
  word_t       result_q;
  word_t       target_q;
  logic        taken;
  logic        writes_rd;

  assign op     = instr[6:0];
  assign raddr1 = instr[19:15];
  assign raddr2 = instr[24:20];

  // Immediate by instruction format
  always_comb begin
    case (op)
      op_store:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      op_branch: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      op_jal:    imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      default:   imm = {{20{instr[31]}}, instr[31:20]};
    endcase
  end

  always_comb begin
    alu_op = alu_add;
    if (op == op_reg || op == op_imm) begin
      case (instr[14:12])
        3'b000:  alu_op = (op == op_reg && instr[30]) ? alu_sub : alu_add;
        3'b100:  alu_op = alu_xor;
        3'b110:  alu_op = alu_or;
        3'b111:  alu_op = alu_and;
        default: alu_op = alu_add;
      endcase
    end
  end

  // ALU second operand is the immediate except for R-type
  assign alu_b = (op_q == op_reg) ? b_q : imm_q;

  always_comb begin
    case (alu_op_q)
      alu_sub: alu_y = a_q - alu_b;
      alu_and: alu_y = a_q & alu_b;
      alu_or:  alu_y = a_q | alu_b;
      alu_xor: alu_y = a_q ^ alu_b;
      default: alu_y = a_q + alu_b;
    endcase
  end

  // BEQ and BNE only
  assign taken = (op_q == op_branch) &&
                 ((f3_q == 3'b000 && a_q == b_q) || (f3_q == 3'b001 && a_q != b_q));

  assign writes_rd = op_q inside {op_reg, op_imm, op_load, op_jal};

  assign we        = (state == st_wb) && writes_rd;
  assign waddr     = rd_q;
  assign wdata     = result_q;
  assign pc_write  = (state == st_wb);
  assign pc_next   = target_q;
  assign mem_write = (op_q == op_store);
  assign mem_addr  = result_q;
  assign mem_wdata = b_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= st_fetch;
      boot        <= 1'b1;
      fetch_start <= 1'b0;
      mem_start   <= 1'b0;
    end else begin
      fetch_start <= 1'b0;
      mem_start   <= 1'b0;
      case (state)
        st_fetch: begin
          // Only the first fetch after reset starts here
          boot        <= 1'b0;
          fetch_start <= boot;
          if (fetch_done) begin
            state <= st_decode;
          end
        end
        st_decode: state <= st_exec;
        st_exec: begin
          if (op_q == op_load || op_q == op_store) begin
            mem_start <= 1'b1;
            state     <= st_mem;
          end else begin
            state <= st_wb;
          end
        end
        st_mem: begin
          if (mem_done) begin
            state <= st_wb;
          end
        end
        st_wb: begin
          fetch_start <= 1'b1;
          state       <= st_fetch;
        end
        default: state <= st_fetch;
      endcase
    end
  end

  // Operand and result registers
  always_ff @(posedge clk) begin
    case (state)
      st_decode: begin
        op_q     <= op;
        rd_q     <= instr[11:7];
        f3_q     <= instr[14:12];
        alu_op_q <= alu_op;
        a_q      <= rdata1;
        b_q      <= rdata2;
        imm_q    <= imm;
      end
      st_exec: begin
        result_q <= (op_q == op_jal) ? pc + 32'd4 : alu_y;
        target_q <= (taken || op_q == op_jal) ? pc + imm_q : pc + 32'd4;
      end
      st_mem: begin
        if (mem_done) begin
          result_q <= mem_rdata;
        end
      end
      default: begin
      end
    endcase
  end

endmodule

//--- rtl/core_top.sv
`timescale 1ns/1ps

module core_top import core_pkg::*; #(
  parameter word_t reset_pc = 32'h0000_0000
) (
  input  logic    clk,
  input  logic    rst_n,
  output rd_req_t ar,
  output logic    arvalid,
  input  logic    arready,
  input  rd_rsp_t r,
  input  logic    rvalid,
  output logic    rready,
  output wr_req_t aw,
  output logic    awvalid,
  input  logic    awready,
  output wr_req_t w,
  output logic    wvalid,
  input  logic    wready,
  input  wr_rsp_t b,
  input  logic    bvalid,
  output logic    bready
);

  logic      fetch_start;
  logic      fetch_done;
  instr_t    instr;
  word_t     pc;
  logic      pc_write;
  word_t     pc_next;
  reg_addr_t raddr1;
  reg_addr_t raddr2;
  word_t     rdata1;
  word_t     rdata2;
  logic      we;
  reg_addr_t waddr;
  word_t     wdata;
  logic      mem_start;
  logic      mem_write;
  word_t     mem_addr;
  word_t     mem_wdata;
  logic      mem_done;
  word_t     mem_rdata;

  // Read masters toward the arbiter
  rd_req_t   f_req;
  rd_req_t   l_req;
  logic      f_valid;
  logic      l_valid;
  logic      f_ready;
  logic      l_ready;
  logic      f_rvalid;
  logic      l_rvalid;
  logic      f_rready;
  logic      l_rready;

  core_control u_control (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_start (fetch_start),
    .fetch_done  (fetch_done),
    .instr       (instr),
    .pc          (pc),
    .pc_write    (pc_write),
    .pc_next     (pc_next),
    .raddr1      (raddr1),
    .raddr2      (raddr2),
    .rdata1      (rdata1),
    .rdata2      (rdata2),
    .we          (we),
    .waddr       (waddr),
    .wdata       (wdata),
    .mem_start   (mem_start),
    .mem_write   (mem_write),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_done    (mem_done),
    .mem_rdata   (mem_rdata)
  );

  core_registers u_registers (
    .clk    (clk),
    .rst_n  (rst_n),
    .raddr1 (raddr1),
    .raddr2 (raddr2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .we     (we),
    .waddr  (waddr),
    .wdata  (wdata)
  );

  core_ifetch #(
    .reset_pc (reset_pc)
  ) u_ifetch (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_start (fetch_start),
    .fetch_done  (fetch_done),
    .instr       (instr),
    .pc          (pc),
    .pc_write    (pc_write),
    .pc_next     (pc_next),
    .req         (f_req),
    .req_valid   (f_valid),
    .req_ready   (f_ready),
    .rsp         (r),
    .rsp_valid   (f_rvalid),
    .rsp_ready   (f_rready)
  );

  core_lsu u_lsu (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_start (mem_start),
    .mem_write (mem_write),
    .addr      (mem_addr),
    .wdata     (mem_wdata),
    .mem_done  (mem_done),
    .rdata     (mem_rdata),
    .req       (l_req),
    .req_valid (l_valid),
    .req_ready (l_ready),
    .rsp       (r),
    .rsp_valid (l_rvalid),
    .rsp_ready (l_rready),
    .aw        (aw),
    .awvalid   (awvalid),
    .awready   (awready),
    .w         (w),
    .wvalid    (wvalid),
    .wready    (wready),
    .b         (b),
    .bvalid    (bvalid),
    .bready    (bready)
  );

  core_rd_arbiter u_rd_arbiter (
    .clk      (clk),
    .rst_n    (rst_n),
    .f_req    (f_req),
    .l_req    (l_req),
    .f_valid  (f_valid),
    .l_valid  (l_valid),
    .f_ready  (f_ready),
    .l_ready  (l_ready),
    .f_rvalid (f_rvalid),
    .l_rvalid (l_rvalid),
    .f_rready (f_rready),
    .l_rready (l_rready),
    .ar       (ar),
    .arvalid  (arvalid),
    .arready  (arready),
    .rvalid   (rvalid),
    .rready   (rready)
  );

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst_n
);

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Reset held for 16 cycles and released just after an edge
  initial begin
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

//--- sim/tb_core.sv
`timescale 1ns/1ps

module tb_core import core_pkg::*; ();

  localparam word_t reset_pc   = 32'h0000_0100;
  localparam int    prog_word  = reset_pc / 4;
  localparam int    n_rand     = 64;
  localparam int    n_prog     = n_rand + 32;
  localparam word_t halt_pc    = reset_pc + 32'(4 * (n_prog - 1));
  localparam word_t data_base  = 32'h0000_0400;
  localparam word_t dump_base  = 32'h0000_0700;
  localparam int    max_cycles = 50000;

  // Instruction kinds of the random program
  localparam int k_add  = 0;
  localparam int k_sub  = 1;
  localparam int k_and  = 2;
  localparam int k_or   = 3;
  localparam int k_xor  = 4;
  localparam int k_addi = 5;
  localparam int k_lw   = 6;
  localparam int k_sw   = 7;
  localparam int k_beq  = 8;
  localparam int k_bne  = 9;
  localparam int k_jal  = 10;

  logic    clk;
  logic    rst_n;
  rd_req_t ar;
  logic    arvalid;
  logic    arready;
  rd_rsp_t r;
  logic    rvalid;
  logic    rready;
  wr_req_t aw;
  logic    awvalid;
  logic    awready;
  wr_req_t w;
  logic    wvalid;
  logic    wready;
  wr_rsp_t b;
  logic    bvalid;
  logic    bready;

  word_t     mem [1024];
  word_t     model_mem [1024];
  word_t     model_regs [32];
  int        p_kind [n_prog];
  reg_addr_t p_rd [n_prog];
  reg_addr_t p_rs1 [n_prog];
  reg_addr_t p_rs2 [n_prog];
  word_t     p_imm [n_prog];
  word_t     exp_pc [$];
  word_t     exp_wr_addr [$];
  word_t     exp_wr_data [$];

  word_t lfsr = 32'h5ad6_bfec;
  int    checks = 0;
  int    errors = 0;
  logic  first_ar = 1'b1;
  logic  seen_r = 1'b0;
  logic  halt_seen = 1'b0;

  // Memory model state
  logic       rd_pend;
  word_t      rd_addr;
  logic       aw_got;
  word_t      aw_addr;
  logic       w_got;
  word_t      w_data;
  logic [3:0] w_strb;
  logic       b_pend;
  logic       ar_wait;
  logic       aw_wait;
  logic       w_wait;
  word_t      ar_hold;
  word_t      aw_hold;
  word_t      w_hold;

  tb_clock clock0 (
    .clk   (clk),
    .rst_n (rst_n)
  );

  core_top #(
    .reset_pc (reset_pc)
  ) dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .ar      (ar),
    .arvalid (arvalid),
    .arready (arready),
    .r       (r),
    .rvalid  (rvalid),
    .rready  (rready),
    .aw      (aw),
    .awvalid (awvalid),
    .awready (awready),
    .w       (w),
    .wvalid  (wvalid),
    .wready  (wready),
    .b       (b),
    .bvalid  (bvalid),
    .bready  (bready)
  );

  function automatic word_t lfsr_step(input word_t s);
    return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic word_t rand_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic coin();
    word_t v;
    v = rand_bits(1);
    return v[0];
  endfunction

  task automatic check_value(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("ERROR %0t %s", $time, msg);
  endtask

  // RV32I encodings straight from the ISA formats
  function automatic word_t encode(input int k);
    word_t i;
    i = p_imm[k];
    case (p_kind[k])
      k_add:  return {7'h00, p_rs2[k], p_rs1[k], 3'b000, p_rd[k], 7'b0110011};
      k_sub:  return {7'h20, p_rs2[k], p_rs1[k], 3'b000, p_rd[k], 7'b0110011};
      k_and:  return {7'h00, p_rs2[k], p_rs1[k], 3'b111, p_rd[k], 7'b0110011};
      k_or:   return {7'h00, p_rs2[k], p_rs1[k], 3'b110, p_rd[k], 7'b0110011};
      k_xor:  return {7'h00, p_rs2[k], p_rs1[k], 3'b100, p_rd[k], 7'b0110011};
      k_addi: return {i[11:0], p_rs1[k], 3'b000, p_rd[k], 7'b0010011};
      k_lw:   return {i[11:0], p_rs1[k], 3'b010, p_rd[k], 7'b0000011};
      k_sw:   return {i[11:5], p_rs2[k], p_rs1[k], 3'b010, i[4:0], 7'b0100011};
      k_beq:  return {i[12], i[10:5], p_rs2[k], p_rs1[k], 3'b000, i[4:1], i[11], 7'b1100011};
      k_bne:  return {i[12], i[10:5], p_rs2[k], p_rs1[k], 3'b001, i[4:1], i[11], 7'b1100011};
      default: return {i[20], i[10:1], i[11], i[19:12], p_rd[k], 7'b1101111};
    endcase
  endfunction

  task automatic build_program();
    int    off;
    word_t v;
    for (int i = 0; i < 1024; i++) begin
      mem[i] = (32'(i) * 32'h9E37_79B9) ^ 32'h5A5A_0000;
    end
    // x0 is among the random registers so its writes get exercised
    for (int k = 0; k < n_rand; k++) begin
      p_kind[k] = int'(rand_bits(4) % 32'd11);
      p_rd[k]   = 5'(rand_bits(3));
      p_rs1[k]  = 5'(rand_bits(3));
      p_rs2[k]  = 5'(rand_bits(3));
      v = rand_bits(12);
      p_imm[k]  = {{20{v[11]}}, v[11:0]};
      if (p_kind[k] == k_lw || p_kind[k] == k_sw) begin
        p_rs1[k] = 5'd0;
        p_imm[k] = data_base + (rand_bits(7) << 2);
      end else if (p_kind[k] >= k_beq) begin
        // Forward only and never past the start of the dump sequence
        off = 1 + int'(rand_bits(2));
        if (k + off > n_rand) begin
          off = n_rand - k;
        end
        p_imm[k] = 32'(4 * off);
      end
    end
    for (int i = 1; i < 32; i++) begin
      p_kind[n_rand + i - 1] = k_sw;
      p_rs1[n_rand + i - 1]  = 5'd0;
      p_rs2[n_rand + i - 1]  = 5'(i);
      p_imm[n_rand + i - 1]  = dump_base + 32'(4 * (i - 1));
    end
    p_kind[n_prog - 1] = k_jal;
    p_rd[n_prog - 1]   = 5'd0;
    p_imm[n_prog - 1]  = '0;
    for (int k = 0; k < n_prog; k++) begin
      mem[prog_word + k] = encode(k);
    end
  endtask

  task automatic set_reg(input reg_addr_t rd, input word_t v);
    if (rd != 5'd0) begin
      model_regs[rd] = v;
    end
  endtask

  // ISA model that records the PC trace and the expected stores
  task automatic run_model();
    word_t pc;
    word_t next;
    word_t a;
    word_t bv;
    word_t ea;
    int    idx;
    int    steps;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    model_mem = mem;
    pc = reset_pc;
    steps = 0;
    while (pc != halt_pc && steps < 1000) begin
      exp_pc.push_back(pc);
      idx  = int'((pc - reset_pc) >> 2);
      a    = model_regs[p_rs1[idx]];
      bv   = model_regs[p_rs2[idx]];
      ea   = a + p_imm[idx];
      next = pc + 32'd4;
      case (p_kind[idx])
        k_add:  set_reg(p_rd[idx], a + bv);
        k_sub:  set_reg(p_rd[idx], a - bv);
        k_and:  set_reg(p_rd[idx], a & bv);
        k_or:   set_reg(p_rd[idx], a | bv);
        k_xor:  set_reg(p_rd[idx], a ^ bv);
        k_addi: set_reg(p_rd[idx], ea);
        k_lw:   set_reg(p_rd[idx], model_mem[ea[11:2]]);
        k_sw: begin
          model_mem[ea[11:2]] = bv;
          exp_wr_addr.push_back(ea);
          exp_wr_data.push_back(bv);
        end
        k_beq: if (a == bv) next = pc + p_imm[idx];
        k_bne: if (a != bv) next = pc + p_imm[idx];
        default: begin
          set_reg(p_rd[idx], pc + 32'd4);
          next = pc + p_imm[idx];
        end
      endcase
      pc = next;
      steps++;
    end
    if (pc != halt_pc) begin
      report_failure("model did not reach the self-jump");
    end
  endtask

  task automatic take_ar(input word_t addr);
    if (first_ar) begin
      check_value("first ar.addr", addr, reset_pc);
      first_ar = 1'b0;
    end
    // Data reads sit above the program
    if (addr < data_base) begin
      if (exp_pc.size() > 0) begin
        check_value("fetch ar.addr", addr, exp_pc.pop_front());
      end else begin
        check_value("fetch ar.addr", addr, halt_pc);
        halt_seen = 1'b1;
      end
    end
  endtask

  task automatic commit_write();
    if (exp_wr_addr.size() == 0) begin
      report_failure("write issued that the program does not contain");
    end else begin
      check_value("aw.addr", aw_addr, exp_wr_addr.pop_front());
      check_value("w.data", w_data, exp_wr_data.pop_front());
    end
    check_value("w.strb", {28'd0, w_strb}, 32'h0000_000F);
    mem[aw_addr[11:2]] = w_data;
  endtask

  // AXI-lite memory that samples on the edge and drives 1 ns later
  initial begin
    arready = 1'b0;
    r       = '0;
    rvalid  = 1'b0;
    awready = 1'b0;
    wready  = 1'b0;
    b       = '0;
    bvalid  = 1'b0;
    forever begin
      @(posedge clk);
      if (!rst_n) begin
        rd_pend = 1'b0;
        aw_got  = 1'b0;
        w_got   = 1'b0;
        b_pend  = 1'b0;
        ar_wait = 1'b0;
        aw_wait = 1'b0;
        w_wait  = 1'b0;
      end else begin
        if (ar_wait) begin
          if (!arvalid) report_failure("arvalid dropped before arready");
          check_value("ar.addr stable", ar.addr, ar_hold);
        end
        if (aw_wait) begin
          if (!awvalid) report_failure("awvalid dropped before awready");
          check_value("aw.addr stable", aw.addr, aw_hold);
        end
        if (w_wait) begin
          if (!wvalid) report_failure("wvalid dropped before wready");
          check_value("w.data stable", w.data, w_hold);
        end
        ar_wait = arvalid && !arready;
        aw_wait = awvalid && !awready;
        w_wait  = wvalid && !wready;
        ar_hold = ar.addr;
        aw_hold = aw.addr;
        w_hold  = w.data;
        if (!seen_r && (awvalid || wvalid)) begin
          report_failure("write issued before the first R transfer");
        end
        if (rvalid && rready) begin
          rd_pend = 1'b0;
          seen_r  = 1'b1;
        end
        if (arvalid && arready) begin
          take_ar(ar.addr);
          rd_pend = 1'b1;
          rd_addr = ar.addr;
        end
        if (awvalid && awready) begin
          aw_got  = 1'b1;
          aw_addr = aw.addr;
        end
        if (wvalid && wready) begin
          w_got  = 1'b1;
          w_data = w.data;
          w_strb = w.strb;
        end
        if (bvalid && bready) b_pend = 1'b0;
        if (aw_got && w_got) begin
          commit_write();
          aw_got = 1'b0;
          w_got  = 1'b0;
          b_pend = 1'b1;
        end
      end
      #1;
      arready = rst_n && !rd_pend && coin();
      if (!rd_pend) begin
        rvalid = 1'b0;
      end else if (!rvalid && coin()) begin
        rvalid = 1'b1;
        r      = '{data: mem[rd_addr[11:2]], resp: 2'b00};
      end
      awready = rst_n && !aw_got && !b_pend && coin();
      wready  = rst_n && !w_got && !b_pend && coin();
      if (!b_pend) begin
        bvalid = 1'b0;
      end else if (!bvalid) begin
        bvalid = coin();
      end
    end
  end

  initial begin
    int cyc;
    build_program();
    run_model();
    cyc = 0;
    while (!rst_n && cyc < 100) begin
      @(negedge clk);
      cyc++;
    end
    if (!rst_n) begin
      report_failure("reset was never released");
    end
    cyc = 0;
    while (!(halt_seen && exp_wr_addr.size() == 0) && cyc < max_cycles) begin
      @(negedge clk);
      cyc++;
    end
    if (!(halt_seen && exp_wr_addr.size() == 0)) begin
      report_failure("timeout before the program reached its self-jump");
    end
    // Register dump written by the closing stores
    for (int i = 1; i < 32; i++) begin
      check_value($sformatf("dump x%0d", i), mem[dump_base[11:2] + 10'(i - 1)], model_regs[i]);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
rtl/core_pkg.sv
rtl/core_registers.sv
rtl/core_ifetch.sv
rtl/core_lsu.sv
rtl/core_rd_arbiter.sv
rtl/core_control.sv
rtl/core_top.sv
sim/tb_clock.sv
sim/tb_core.sv

//--- Makefile
TOP = tb_core

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f -o sim_tb

run: build
	./obj_dir/sim_tb | tee sim.log
	grep -q "^TB PASSED$$" sim.log

lint:
	verilator --lint-only --timing --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
